/* Bender.yml */
package:
  name: gb_bus

sources:
  - files:
      - common/gb_bus_pkg.sv
      - access/work_ram.sv
      - access/interrupt_flags.sv
      - access/access_stage.sv
      - decode/addr_decode_stage.sv
      - rtl/gb_bus_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/gb_bus_tb.sv

/* access/access_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Second bus pipeline stage
// Boot overlay register, work RAM, IF register
// Read data select and external port strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module access_stage #(
   parameter int wram_addr_bits = 13
) (
   input  wire                            clock,
   input  wire                            reset,
   input  wire gb_bus_pkg::decoded_req_t  dreq,
   input  wire                            irq_vblank_pulse,
   input  wire                            irq_lcd_pulse,
   input  wire                            irq_timer_pulse,
   input  wire                            irq_joypad_pulse,
   input  wire gb_bus_pkg::data_t         ext_rdata,
   output logic                           boot_disable,
   output logic                           rd_valid,
   output gb_bus_pkg::data_t              rd_data,
   output gb_bus_pkg::irq_flags_t         if_flags,
   output gb_bus_pkg::addr_t              ext_addr,
   output logic                           ext_boot_rd,
   output logic                           ext_cart_rd
);

   localparam int flag_bits = $bits(gb_bus_pkg::irq_flags_t);

   gb_bus_pkg::data_t   boot_ctrl;
   gb_bus_pkg::addr_t   ram_base;
   gb_bus_pkg::addr_t   ram_offset;
   gb_bus_pkg::data_t   ram_rdata;
   gb_bus_pkg::data_t   ext_data_q;
   gb_bus_pkg::region_t rd_src_q;
   logic                ram_we;
   logic                if_wr;

   // External port sees the request address directly
   assign ext_addr    = dreq.req.addr;
   assign ext_boot_rd = dreq.req.rd && (dreq.region == gb_bus_pkg::region_boot);
   assign ext_cart_rd = dreq.req.rd && (dreq.region == gb_bus_pkg::region_cart);

   // Boot overlay control at FF50
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         boot_ctrl <= '0;
      end else if (dreq.req.wr && (dreq.region == gb_bus_pkg::region_boot_ctrl)) begin
         boot_ctrl <= dreq.req.wdata;
      end
   end

   assign boot_disable = boot_ctrl[0];

   // Echo reads map onto work RAM and echo writes are dropped
   assign ram_base   = (dreq.region == gb_bus_pkg::region_echo) ?
                       gb_bus_pkg::echo_start : gb_bus_pkg::wram_start;
   assign ram_offset = dreq.req.addr - ram_base;
   assign ram_we     = dreq.req.wr && (dreq.region == gb_bus_pkg::region_wram);
   assign if_wr      = dreq.req.wr && (dreq.region == gb_bus_pkg::region_if);

   work_ram #(
      .wram_addr_bits (wram_addr_bits)
   ) i_work_ram (
      .clock (clock),
      .we    (ram_we),
      .addr  (ram_offset[wram_addr_bits-1:0]),
      .wdata (dreq.req.wdata),
      .rdata (ram_rdata)
   );

   interrupt_flags i_interrupt_flags (
      .clock            (clock),
      .reset            (reset),
      .irq_vblank_pulse (irq_vblank_pulse),
      .irq_lcd_pulse    (irq_lcd_pulse),
      .irq_timer_pulse  (irq_timer_pulse),
      .irq_joypad_pulse (irq_joypad_pulse),
      .wr               (if_wr),
      .wdata            (dreq.req.wdata[flag_bits-1:0]),
      .flags            (if_flags)
   );

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         rd_valid <= 1'b0;
         rd_src_q <= gb_bus_pkg::region_junk;
      end else begin
         rd_valid <= dreq.req.rd;
         rd_src_q <= dreq.region;
      end
   end

   // Sample external data in the same cycle as the strobe
   always_ff @(posedge clock) begin
      ext_data_q <= ext_rdata;
   end

   always_comb begin
      case (rd_src_q)
         gb_bus_pkg::region_boot,
         gb_bus_pkg::region_cart:      rd_data = ext_data_q;
         gb_bus_pkg::region_wram,
         gb_bus_pkg::region_echo:      rd_data = ram_rdata;
         gb_bus_pkg::region_if:        rd_data = {{(8 - flag_bits){1'b0}}, if_flags};
         gb_bus_pkg::region_boot_ctrl: rd_data = boot_ctrl;
         default:                      rd_data = '0;
      endcase
   end

   // Work RAM and echo addresses never reach past the RAM depth
   ram_offset_in_range: assert property (
      @(posedge clock) disable iff (reset)
      ((dreq.region == gb_bus_pkg::region_wram) ||
       (dreq.region == gb_bus_pkg::region_echo)) |->
      ((ram_offset >> wram_addr_bits) == '0)
   );

endmodule

`default_nettype wire

/* access/interrupt_flags.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Interrupt flag register at FF0F
// Pulses set bits and a bus write replaces all
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module interrupt_flags (
   input  wire                           clock,
   input  wire                           reset,
   input  wire                           irq_vblank_pulse,
   input  wire                           irq_lcd_pulse,
   input  wire                           irq_timer_pulse,
   input  wire                           irq_joypad_pulse,
   input  wire                           wr,
   input  wire gb_bus_pkg::irq_flags_t   wdata,
   output gb_bus_pkg::irq_flags_t        flags
);

   gb_bus_pkg::irq_flags_t set_mask;
   gb_bus_pkg::irq_flags_t write_val;

   // Serial has no source in this build
   always_comb begin
      set_mask = '0;
      set_mask[gb_bus_pkg::irq_vblank] = irq_vblank_pulse;
      set_mask[gb_bus_pkg::irq_lcd]    = irq_lcd_pulse;
      set_mask[gb_bus_pkg::irq_timer]  = irq_timer_pulse;
      set_mask[gb_bus_pkg::irq_joypad] = irq_joypad_pulse;
   end

   always_comb begin
      write_val = wdata;
      write_val[gb_bus_pkg::irq_serial] = 1'b0;
   end

   // Bus write wins over a pulse at the same edge
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         flags <= '0;
      end else if (wr) begin
         flags <= write_val;
      end else begin
         flags <= flags | set_mask;
      end
   end

   // Each interrupt source strobes for a single cycle
   pulse_single_cycle: assert property (
      @(posedge clock) disable iff (reset)
      (set_mask & $past(set_mask)) == '0
   );

endmodule

`default_nettype wire

/* access/work_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Work RAM, single port block RAM
// Registered read, read-first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module work_ram #(
   parameter int wram_addr_bits = 13
) (
   input  wire                      clock,
   input  wire                      we,
   input  wire [wram_addr_bits-1:0] addr,
   input  wire gb_bus_pkg::data_t   wdata,
   output gb_bus_pkg::data_t        rdata
);

   localparam int depth = 2 ** wram_addr_bits;

   gb_bus_pkg::data_t mem [depth];

   // Old contents come out when a write hits the same address
   always_ff @(posedge clock) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      rdata <= mem[addr];
   end

endmodule

`default_nettype wire

/* bench/gb_bus_tb_table.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Step table for the system bus testbench
// Columns are name, operation, address, data, expected read value
// Data holds a slot number for random RAM steps, a flag mask for pulses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef GB_BUS_TB_TABLE_SVH
`define GB_BUS_TB_TABLE_SVH

task automatic load_steps();
   // Boot overlay, boot model is low byte ^ 5A, cartridge model low byte ^ C3
   add_step("flags_after_reset",   op_flags,      16'h0000, 8'h00, 8'h00);
   add_step("boot_0000",           op_read,       16'h0000, 8'h00, 8'h5A);
   add_step("boot_0102",           op_read,       16'h0102, 8'h00, 8'h58);
   add_step("boot_hole_0103",      op_read,       16'h0103, 8'h00, 8'h00);
   add_step("cart_0104_in_boot",   op_read,       16'h0104, 8'h00, 8'hC7);
   add_step("boot_ctrl_write",     op_write,      16'hFF50, 8'h01, 8'h00);
   add_step("boot_ctrl_read",      op_read,       16'hFF50, 8'h00, 8'h01);
   add_step("cart_0000_after",     op_read,       16'h0000, 8'h00, 8'hC3);
   add_step("cart_0102_after",     op_read,       16'h0102, 8'h00, 8'hC1);

   // Work RAM and echo mirror
   add_step("wram_c000_write",     op_write_rand, 16'hC000, 8'd0,  8'h00);
   add_step("wram_c123_write",     op_write_rand, 16'hC123, 8'd1,  8'h00);
   add_step("wram_dfff_write",     op_write_rand, 16'hDFFF, 8'd2,  8'h00);
   add_step("wram_c000_read",      op_read_rand,  16'hC000, 8'd0,  8'h00);
   add_step("wram_c123_read",      op_read_rand,  16'hC123, 8'd1,  8'h00);
   add_step("wram_dfff_read",      op_read_rand,  16'hDFFF, 8'd2,  8'h00);
   add_step("echo_e123_read",      op_read_rand,  16'hE123, 8'd1,  8'h00);
   add_step("wram_c010_write",     op_write_rand, 16'hC010, 8'd3,  8'h00);
   add_step("echo_e010_write",     op_write,      16'hE010, 8'h5C, 8'h00);
   add_step("wram_c010_kept",      op_read_rand,  16'hC010, 8'd3,  8'h00);

   // Back-to-back traffic
   add_step("b2b_c200_write",      op_write_rand, 16'hC200, 8'd4,  8'h00);
   add_step("b2b_c200_read",       op_read_rand,  16'hC200, 8'd4,  8'h00);
   add_step("run_c000",            op_read_rand,  16'hC000, 8'd0,  8'h00);
   add_step("run_ff50",            op_read,       16'hFF50, 8'h00, 8'h01);
   add_step("run_dfff",            op_read_rand,  16'hDFFF, 8'd2,  8'h00);
   add_step("run_0104",            op_read,       16'h0104, 8'h00, 8'hC7);

   // Interrupt flags
   add_step("timer_pulse",         op_pulse,      16'h0000, 8'h04, 8'h00);
   add_step("vblank_pulse",        op_pulse,      16'h0000, 8'h01, 8'h00);
   add_step("flags_timer_vblank",  op_flags,      16'h0000, 8'h00, 8'h05);
   add_step("if_read_05",          op_read,       16'hFF0F, 8'h00, 8'h05);
   add_step("if_write_10",         op_write,      16'hFF0F, 8'h10, 8'h00);
   add_step("if_read_10",          op_read,       16'hFF0F, 8'h00, 8'h10);
   add_step("flags_after_write",   op_flags,      16'h0000, 8'h00, 8'h10);
   add_step("if_write_00",         op_write,      16'hFF0F, 8'h00, 8'h00);
   add_step("joypad_same_edge",    op_pulse,      16'h0000, 8'h10, 8'h00);
   add_step("flags_write_wins",    op_flags,      16'h0000, 8'h00, 8'h00);
   add_step("if_read_00",          op_read,       16'hFF0F, 8'h00, 8'h00);

   // Unmapped space
   add_step("junk_ff00_read",      op_read,       16'hFF00, 8'h00, 8'h00);
   add_step("junk_ff40_read",      op_read,       16'hFF40, 8'h00, 8'h00);
   add_step("junk_ff00_write",     op_write,      16'hFF00, 8'hFF, 8'h00);
   add_step("junk_ff40_write",     op_write,      16'hFF40, 8'hFF, 8'h00);
   add_step("settle",              op_idle,       16'h0000, 8'h00, 8'h00);
   add_step("boot_ctrl_kept",      op_read,       16'hFF50, 8'h00, 8'h01);
   add_step("if_kept",             op_read,       16'hFF0F, 8'h00, 8'h00);
   add_step("wram_c000_kept",      op_read_rand,  16'hC000, 8'd0,  8'h00);
   add_step("cart_0000_kept",      op_read,       16'h0000, 8'h00, 8'hC3);
   add_step("echo_e123_kept",      op_read_rand,  16'hE123, 8'd1,  8'h00);
endtask

`endif

/* bench/gb_bus_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the system bus
// Clock, reset, external ROM model, step loop and checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module gb_bus_tb;

   typedef enum logic [2:0] {
      op_idle,
      op_read,
      op_write,
      op_read_rand,
      op_write_rand,
      op_pulse,
      op_flags
   } op_t;

   typedef struct packed {
      op_t               op;
      gb_bus_pkg::addr_t addr;
      gb_bus_pkg::data_t data;
      gb_bus_pkg::data_t exp_data;
   } step_t;

   // Cycles to wait for the last read result
   localparam int read_timeout = 16;

   logic                   clock;
   logic                   reset;
   gb_bus_pkg::bus_req_t   req;
   logic                   rd_valid;
   gb_bus_pkg::data_t      rd_data;
   logic                   irq_vblank_pulse;
   logic                   irq_lcd_pulse;
   logic                   irq_timer_pulse;
   logic                   irq_joypad_pulse;
   gb_bus_pkg::irq_flags_t if_flags;
   gb_bus_pkg::addr_t      ext_addr;
   logic                   ext_boot_rd;
   logic                   ext_cart_rd;
   gb_bus_pkg::data_t      ext_rdata;

   step_t                  steps[$];
   string                  step_names[$];
   gb_bus_pkg::data_t      rand_bytes[8];
   int                     pending_step[$];
   int                     pending_cycle[$];
   int                     cycle;

   gb_bus_top #(
      .wram_addr_bits (13)
   ) i_gb_bus_top (
      .clock            (clock),
      .reset            (reset),
      .req              (req),
      .rd_valid         (rd_valid),
      .rd_data          (rd_data),
      .irq_vblank_pulse (irq_vblank_pulse),
      .irq_lcd_pulse    (irq_lcd_pulse),
      .irq_timer_pulse  (irq_timer_pulse),
      .irq_joypad_pulse (irq_joypad_pulse),
      .if_flags         (if_flags),
      .ext_addr         (ext_addr),
      .ext_boot_rd      (ext_boot_rd),
      .ext_cart_rd      (ext_cart_rd),
      .ext_rdata        (ext_rdata)
   );

   always begin
      #10 clock = ~clock;
   end

   // Boot ROM and cartridge model
   // Idle value EE when nothing is strobed
   always_comb begin
      if (ext_boot_rd) begin
         ext_rdata = ext_addr[7:0] ^ 8'h5A;
      end else if (ext_cart_rd) begin
         ext_rdata = ext_addr[7:0] ^ 8'hC3;
      end else begin
         ext_rdata = 8'hEE;
      end
   end

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input gb_bus_pkg::data_t expected,
                              input gb_bus_pkg::data_t actual);
      if (actual !== expected) begin
         stop_with_failure($sformatf("FAIL %s expected %02h actual %02h",
                                     name, expected, actual));
      end
   endtask

   task automatic add_step(input string name, input op_t op, input gb_bus_pkg::addr_t addr,
                           input gb_bus_pkg::data_t data, input gb_bus_pkg::data_t exp_data);
      step_t s;
      s.op       = op;
      s.addr     = addr;
      s.data     = data;
      s.exp_data = exp_data;
      steps.push_back(s);
      step_names.push_back(name);
   endtask

   `include "gb_bus_tb_table.svh"

   function automatic logic is_read(input op_t op);
      return (op == op_read) || (op == op_read_rand);
   endfunction

   task automatic drive_idle();
      req              = '0;
      irq_vblank_pulse = 1'b0;
      irq_lcd_pulse    = 1'b0;
      irq_timer_pulse  = 1'b0;
      irq_joypad_pulse = 1'b0;
   endtask

   // Results are due exactly two edges after the request
   task automatic sample_read_result();
      int idx;
      int issued;
      if (rd_valid === 1'b1) begin
         if (pending_step.size() == 0) begin
            stop_with_failure("Read data came back while no read was pending");
         end else begin
            idx    = pending_step.pop_front();
            issued = pending_cycle.pop_front();
            if (cycle - issued != 2) begin
               stop_with_failure($sformatf("Read data for %s came %0d cycles after the request",
                                           step_names[idx], cycle - issued));
            end else begin
               check_value(step_names[idx], steps[idx].exp_data, rd_data);
            end
         end
      end
   endtask

   task automatic apply_step(input int i);
      int          slot;
      int unsigned rand_word;
      drive_idle();
      slot = steps[i].data[2:0];
      case (steps[i].op)
         op_read, op_read_rand: begin
            if (steps[i].op == op_read_rand) begin
               steps[i].exp_data = rand_bytes[slot];
            end
            req.rd   = 1'b1;
            req.addr = steps[i].addr;
            pending_step.push_back(i);
            pending_cycle.push_back(cycle);
         end
         op_write, op_write_rand: begin
            if (steps[i].op == op_write_rand) begin
               rand_word        = $urandom;
               rand_bytes[slot] = rand_word[7:0];
               steps[i].data    = rand_word[7:0];
            end
            req.wr    = 1'b1;
            req.addr  = steps[i].addr;
            req.wdata = steps[i].data;
         end
         op_pulse: begin
            irq_vblank_pulse = steps[i].data[gb_bus_pkg::irq_vblank];
            irq_lcd_pulse    = steps[i].data[gb_bus_pkg::irq_lcd];
            irq_timer_pulse  = steps[i].data[gb_bus_pkg::irq_timer];
            irq_joypad_pulse = steps[i].data[gb_bus_pkg::irq_joypad];
         end
         op_flags: begin
            check_value(step_names[i], steps[i].exp_data, {3'b000, if_flags});
         end
         default: begin
         end
      endcase
   endtask

   task automatic drain_reads();
      int waited;
      waited = 0;
      while (pending_step.size() != 0) begin
         @(negedge clock);
         cycle++;
         drive_idle();
         sample_read_result();
         waited++;
         if (waited > read_timeout && pending_step.size() != 0) begin
            stop_with_failure("No read data arrived before the timeout");
         end
      end
   endtask

   initial begin
      int i;
      clock = 1'b0;
      reset = 1'b1;
      cycle = 0;
      drive_idle();
      void'($urandom(32'h911e_f3f1));
      load_steps();
      repeat (3) @(negedge clock);
      reset = 1'b0;
      for (i = 0; i < steps.size(); i++) begin
         @(negedge clock);
         cycle++;
         sample_read_result();
         apply_step(i);
         // Reads in a row stay in flight together
         if (i == steps.size() - 1 || !is_read(steps[i + 1].op)) begin
            drain_reads();
         end
      end
      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

/* common/gb_bus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// System bus types and memory map constants
// Region enum and the two pipeline request structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package gb_bus_pkg;

   typedef logic [15:0] addr_t;
   typedef logic [7:0]  data_t;

   // Interrupt flag vector, same bit order as the IF register
   typedef logic [4:0]  irq_flags_t;

   localparam logic [2:0] irq_vblank = 3'd0;
   localparam logic [2:0] irq_lcd    = 3'd1;
   localparam logic [2:0] irq_timer  = 3'd2;
   localparam logic [2:0] irq_serial = 3'd3;
   localparam logic [2:0] irq_joypad = 3'd4;

   // Boot ROM overlay, only while the overlay is enabled
   localparam addr_t boot_end        = 16'h0102;

   // Cartridge ROM space
   localparam addr_t cart_start      = 16'h0000;
   localparam addr_t cart_end        = 16'h7FFF;
   // First cartridge byte visible while boot ROM is mapped
   localparam addr_t cart_start_boot = 16'h0104;

   localparam addr_t wram_start      = 16'hC000;
   localparam addr_t wram_end        = 16'hDFFF;

   // Mirror of work RAM
   localparam addr_t echo_start      = 16'hE000;
   localparam addr_t echo_end        = 16'hFDFF;

   // Memory mapped registers
   localparam addr_t mmio_if         = 16'hFF0F;
   localparam addr_t mmio_boot_ctrl  = 16'hFF50;

   typedef enum logic [2:0] {
      region_junk,
      region_boot,
      region_cart,
      region_wram,
      region_echo,
      region_if,
      region_boot_ctrl
   } region_t;

   // CPU request as seen on the bus
   typedef struct packed {
      logic  rd;
      logic  wr;
      addr_t addr;
      data_t wdata;
   } bus_req_t;

   // Request after the decode stage
   typedef struct packed {
      bus_req_t req;
      region_t  region;
   } decoded_req_t;

endpackage

`default_nettype wire

/* decode/addr_decode_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// First bus pipeline stage
// Memory map decode with boot ROM overlay
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module addr_decode_stage (
   input  wire                          clock,
   input  wire                          reset,
   input  wire gb_bus_pkg::bus_req_t    req,
   input  wire                          boot_disable,
   output gb_bus_pkg::decoded_req_t     dreq
);

   gb_bus_pkg::region_t region;
   gb_bus_pkg::addr_t   cart_low;
   logic                in_boot;
   logic                in_cart;
   logic                in_wram;
   logic                in_echo;

   // Cartridge space starts after the boot ROM while it is mapped
   assign cart_low = boot_disable ? gb_bus_pkg::cart_start : gb_bus_pkg::cart_start_boot;

   assign in_boot = !boot_disable && (req.addr <= gb_bus_pkg::boot_end);
   assign in_cart = (req.addr >= cart_low) && (req.addr <= gb_bus_pkg::cart_end);
   assign in_wram = (req.addr >= gb_bus_pkg::wram_start) &&
                    (req.addr <= gb_bus_pkg::wram_end);
   assign in_echo = (req.addr >= gb_bus_pkg::echo_start) &&
                    (req.addr <= gb_bus_pkg::echo_end);

   // Boot ROM has priority over the cartridge range
   always_comb begin
      if (in_boot) begin
         region = gb_bus_pkg::region_boot;
      end else if (in_cart) begin
         region = gb_bus_pkg::region_cart;
      end else if (in_wram) begin
         region = gb_bus_pkg::region_wram;
      end else if (in_echo) begin
         region = gb_bus_pkg::region_echo;
      end else if (req.addr == gb_bus_pkg::mmio_if) begin
         region = gb_bus_pkg::region_if;
      end else if (req.addr == gb_bus_pkg::mmio_boot_ctrl) begin
         region = gb_bus_pkg::region_boot_ctrl;
      end else begin
         // 0103 during boot lands here too
         region = gb_bus_pkg::region_junk;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         dreq <= '0;
      end else begin
         dreq.req    <= req;
         dreq.region <= region;
      end
   end

   // The CPU never reads and writes in the same cycle
   rd_wr_exclusive: assert property (
      @(posedge clock) disable iff (reset)
      !(req.rd && req.wr)
   );

endmodule

`default_nettype wire

/* flist.f */
+incdir+bench
common/gb_bus_pkg.sv
access/work_ram.sv
access/interrupt_flags.sv
access/access_stage.sv
decode/addr_decode_stage.sv
rtl/gb_bus_top.sv
bench/gb_bus_tb.sv

/* rtl/gb_bus_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// System bus top level
// Decode stage, access stage and external port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module gb_bus_top #(
   parameter int wram_addr_bits = 13
) (
   input  wire                        clock,
   input  wire                        reset,

   // CPU request strobes
   input  wire gb_bus_pkg::bus_req_t  req,

   // Read result, two edges after the request
   output logic                       rd_valid,
   output gb_bus_pkg::data_t          rd_data,

   // Interrupt sources
   input  wire                        irq_vblank_pulse,
   input  wire                        irq_lcd_pulse,
   input  wire                        irq_timer_pulse,
   input  wire                        irq_joypad_pulse,
   output gb_bus_pkg::irq_flags_t     if_flags,

   // Shared port to boot ROM and cartridge
   output gb_bus_pkg::addr_t          ext_addr,
   output logic                       ext_boot_rd,
   output logic                       ext_cart_rd,
   input  wire gb_bus_pkg::data_t     ext_rdata
);

   gb_bus_pkg::decoded_req_t dreq;
   logic                     boot_disable;

   addr_decode_stage i_addr_decode_stage (
      .clock        (clock),
      .reset        (reset),
      .req          (req),
      .boot_disable (boot_disable),
      .dreq         (dreq)
   );

   access_stage #(
      .wram_addr_bits (wram_addr_bits)
   ) i_access_stage (
      .clock            (clock),
      .reset            (reset),
      .dreq             (dreq),
      .irq_vblank_pulse (irq_vblank_pulse),
      .irq_lcd_pulse    (irq_lcd_pulse),
      .irq_timer_pulse  (irq_timer_pulse),
      .irq_joypad_pulse (irq_joypad_pulse),
      .ext_rdata        (ext_rdata),
      .boot_disable     (boot_disable),
      .rd_valid         (rd_valid),
      .rd_data          (rd_data),
      .if_flags         (if_flags),
      .ext_addr         (ext_addr),
      .ext_boot_rd      (ext_boot_rd),
      .ext_cart_rd      (ext_cart_rd)
   );

endmodule

`default_nettype wire
